// ==== adsr_env.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "synth_macros.svh"

module adsr_env (
   input  wire logic              clk,
   input  wire logic              rstn,
   input  wire logic              frame_tick,
   input  wire logic              gate,
   input  wire logic [1:0]        adsr_sel,
   output synth_pkg::env_level_t  level,
   output logic                   active
);

   localparam synth_pkg::env_level_t lvl_max   = synth_pkg::env_level_t'(`LEVEL_MAX);
   localparam synth_pkg::env_level_t slow_step = synth_pkg::env_level_t'(`SLOW_STEP);

   synth_pkg::env_state_t state;
   synth_pkg::env_state_t next_state;
   synth_pkg::env_level_t next_level;
   synth_pkg::env_level_t attack_step;
   synth_pkg::env_level_t decay_step;
   synth_pkg::env_level_t sustain_lvl;
   logic [6:0]            rise_sum;    // one extra bit for saturation
   logic [6:0]            decay_floor;

   // preset decode
   always_comb
   begin
      case (adsr_sel)
         2'd0:
         begin
            attack_step = lvl_max;
            decay_step  = lvl_max;
            sustain_lvl = lvl_max;
         end
         2'd1:
         begin
            attack_step = lvl_max;
            decay_step  = lvl_max;
            sustain_lvl = '0;
         end
         2'd2:
         begin
            attack_step = slow_step;
            decay_step  = lvl_max;
            sustain_lvl = lvl_max;
         end
         default:
         begin
            attack_step = slow_step;
            decay_step  = slow_step;
            sustain_lvl = '0;
         end
      endcase
   end

   assign rise_sum    = {1'b0, level} + {1'b0, attack_step};
   assign decay_floor = {1'b0, sustain_lvl} + {1'b0, decay_step};

   always_comb
   begin
      next_state = state;
      next_level = level;
      if (!gate)
      begin
         next_state = synth_pkg::env_idle;  // release is instant
         next_level = '0;
      end
      else
      begin
         case (state)
            synth_pkg::env_idle, synth_pkg::env_attack:
            begin
               if (rise_sum >= {1'b0, lvl_max})
               begin
                  next_level = lvl_max;
                  next_state = synth_pkg::env_decay;
               end
               else
               begin
                  next_level = rise_sum[5:0];
                  next_state = synth_pkg::env_attack;
               end
            end
            synth_pkg::env_decay:
            begin
               // stop at the sustain level
               if ({1'b0, level} <= decay_floor)
               begin
                  next_level = sustain_lvl;
                  next_state = synth_pkg::env_sustain;
               end
               else
                  next_level = level - decay_step;
            end
            default: ;  // sustain holds
         endcase
      end
   end

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         state <= synth_pkg::env_idle;
         level <= '0;
      end
      else if (frame_tick)
      begin
         state <= next_state;
         level <= next_level;
      end
   end

   assign active = (state != synth_pkg::env_idle);

endmodule

`default_nettype wire

// ==== input_sync.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "synth_macros.svh"

module input_sync (
   input  wire logic                    clk,
   input  wire logic                    rstn,
   input  wire logic [`NSWITCHES-1:0]   sw,
   input  wire logic [`NNOTES-1:0]      note_enn,
   output synth_pkg::switch_cfg_t       cfg,
   output logic      [`NNOTES-1:0]      note_en
);

   logic [`NSWITCHES-1:0] sw_q  [`SYNC_STAGES];
   logic [`NNOTES-1:0]    key_q [`SYNC_STAGES];  // still active low

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         for (int i = 0; i < `SYNC_STAGES; i++)
         begin
            sw_q[i]  <= '0;
            key_q[i] <= '1;  // all keys released
         end
      end
      else
      begin
         sw_q[0]  <= sw;
         key_q[0] <= note_enn;
         for (int i = 1; i < `SYNC_STAGES; i++)
         begin
            sw_q[i]  <= sw_q[i-1];
            key_q[i] <= key_q[i-1];
         end
      end
   end

   assign cfg     = synth_pkg::switch_cfg_t'(sw_q[`SYNC_STAGES-1]);
   assign note_en = ~key_q[`SYNC_STAGES-1];  // active high from here on

endmodule

`default_nettype wire

// ==== note_select.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "synth_macros.svh"

module note_select (
   input  wire logic [3:0]           cfg_note_set,
   input  wire logic [`NNOTES-1:0]   note_en,
   output synth_pkg::note_code_t     note,
   output logic                      gate
);

   logic [2:0] key_idx;

   // lowest numbered pressed key wins
   always_comb
   begin
      key_idx = '0;
      for (int i = `NNOTES - 1; i >= 0; i--)
      begin
         if (note_en[i])
            key_idx = 3'(i);
      end
   end

   always_comb
   begin
      note = synth_pkg::scale_note(cfg_note_set, key_idx);
      gate = |note_en;
   end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
synth_pkg.sv
input_sync.sv
note_select.sv
adsr_env.sv
wave_osc.sv
pwm_dac.sv
synth_top.sv
synth_chk.sv
synth_tb.sv

// ==== pwm_dac.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "synth_macros.svh"

module pwm_dac (
   input  wire logic                   clk,
   input  wire logic                   rstn,
   input  wire synth_pkg::sample_t     sample,
   input  wire synth_pkg::env_level_t  level,
   output logic                        frame_tick,
   output logic                        pwm_out
);

   logic [`PWM_BITS-1:0] frame_cnt;
   synth_pkg::duty_t     duty;
   synth_pkg::duty_t     on_cnt;

   // free running frame counter
   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
         frame_cnt <= '0;
      else
         frame_cnt <= frame_cnt + 1'b1;
   end

   assign frame_tick = (frame_cnt == '1);

   // additive mix, offset moves signed sample into duty range
   assign duty = synth_pkg::duty_t'(sample)
               + synth_pkg::duty_t'(level)
               + synth_pkg::duty_t'(`DUTY_OFFSET);

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
         on_cnt <= '0;
      else if (frame_tick)
         on_cnt <= duty;
      else if (on_cnt != '0)
         on_cnt <= on_cnt - 1'b1;
   end

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
         pwm_out <= 1'b0;
      else
         pwm_out <= (on_cnt != '0);  // high for duty cycles after the tick
   end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the synth testbench with Verilator
verilator --binary --timing --assert -f project.f --top-module synth_tb -o synth_sim \
   > build.log 2>&1 \
   && ./obj_dir/synth_sim > sim.log 2>&1 \
   ; grep -q "All checks passed" sim.log \
   && ! grep -q "Checks failed" sim.log \
   && echo "PASS" \
   || { echo "FAIL, see build.log and sim.log"; exit 1; }

// ==== synth_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module synth_chk (
   input wire logic clk,
   input wire logic rstn,
   input wire logic frame_tick,
   input wire logic gate,
   input wire logic active,
   input wire logic pwm_out
);

   // one tick per 256 clocks
   a_tick_period : assert property (@(posedge clk) disable iff (!rstn)
      frame_tick |=> (!frame_tick) [*255] ##1 frame_tick)
      else $error("frame_tick period is not 256 cycles");

   a_pwm_reset : assert property (@(posedge clk)
      !rstn |-> !pwm_out)
      else $error("pwm_out high during reset");

   // released at a tick means idle until the next one
   a_gate_idle : assert property (@(posedge clk) disable iff (!rstn)
      (frame_tick && !gate) |=> !active)
      else $error("active high after a tick with gate low");

   // the single pulse starts right after the counter loads
   a_pwm_rise : assert property (@(posedge clk) disable iff (!rstn)
      $rose(pwm_out) |-> $past(frame_tick, 2))
      else $error("pwm_out rose away from a tick");

endmodule

bind synth_top synth_chk chk_i (
   .clk        (clk),
   .rstn       (rstn),
   .frame_tick (frame_tick),
   .gate       (gate),
   .active     (active),
   .pwm_out    (pwm_out)
);

`default_nettype wire

// ==== synth_macros.svh ====
`ifndef SYNTH_MACROS_SVH
`define SYNTH_MACROS_SVH

// keyboard and switch bank
`define NNOTES      5
`define NSWITCHES   8
`define SYNC_STAGES 3

// pwm frame, one frame is 2**PWM_BITS clocks
`define PWM_BITS    8

// envelope
`define LEVEL_MAX   63
`define SLOW_STEP   4

// oscillator and mixer
`define NOTE_BASE   56  // lowest note code maps to phase step 1
`define DUTY_OFFSET 127

`endif

// ==== synth_pkg.sv ====
`default_nettype none

`include "synth_macros.svh"

package synth_pkg;

   typedef logic [6:0]               note_code_t;  // 57 (C) .. 69 (high C)
   typedef logic [5:0]               env_level_t;
   typedef logic signed [7:0]        sample_t;
   typedef logic [`PWM_BITS-1:0]     duty_t;

   typedef struct packed {
      logic [3:0] note_set;  // sw[7:4]
      logic [1:0] adsr_sel;  // sw[3:2]
      logic [1:0] wave_sel;  // sw[1:0]
   } switch_cfg_t;

   typedef enum logic [1:0] {
      env_idle,
      env_attack,
      env_decay,
      env_sustain
   } env_state_t;

   // five-note scale sets, entry 0 belongs to key 0
   function automatic note_code_t scale_note(input logic [3:0] set, input logic [2:0] key);
      note_code_t [0:`NNOTES-1] row;
      case (set)
         4'd0:    row = '{7'd57, 7'd60, 7'd62, 7'd64, 7'd67};
         4'd1:    row = '{7'd57, 7'd60, 7'd64, 7'd67, 7'd69};
         4'd2:    row = '{7'd57, 7'd60, 7'd62, 7'd64, 7'd65};
         4'd3:    row = '{7'd59, 7'd61, 7'd63, 7'd64, 7'd66};
         4'd4:    row = '{7'd57, 7'd59, 7'd60, 7'd62, 7'd65};
         4'd5:    row = '{7'd57, 7'd59, 7'd64, 7'd66, 7'd67};
         4'd6:    row = '{7'd57, 7'd59, 7'd60, 7'd62, 7'd64};
         4'd7:    row = '{7'd57, 7'd59, 7'd61, 7'd63, 7'd64};
         4'd8:    row = '{7'd59, 7'd61, 7'd62, 7'd64, 7'd65};
         4'd9:    row = '{7'd57, 7'd60, 7'd62, 7'd64, 7'd66};
         4'd10:   row = '{7'd60, 7'd62, 7'd64, 7'd65, 7'd69};
         4'd11:   row = '{7'd57, 7'd61, 7'd64, 7'd68, 7'd69};
         4'd12:   row = '{7'd57, 7'd59, 7'd61, 7'd64, 7'd66};
         4'd13:   row = '{7'd59, 7'd60, 7'd64, 7'd65, 7'd67};
         4'd14:   row = '{7'd62, 7'd64, 7'd66, 7'd68, 7'd69};
         default: row = '{7'd57, 7'd59, 7'd61, 7'd62, 7'd64};
      endcase
      if (key < 3'(`NNOTES))
         return row[key];
      return row[0];  // out of range key, fall back to key 0
   endfunction

endpackage

`default_nettype wire

// ==== synth_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "synth_macros.svh"

module synth_tb;

   localparam int frame_len  = 256;
   localparam int run_frames = 300;
   localparam int limit_ns   = (run_frames + 10) * frame_len * 40;

   logic                  clk;
   logic                  rstn;
   logic [`NSWITCHES-1:0] sw;
   logic [`NNOTES-1:0]    note_enn;
   wire logic             pwm_out;

   logic [31:0]           lfsr;
   logic [`NSWITCHES-1:0] m_sw  [`SYNC_STAGES];
   logic [`NNOTES-1:0]    m_key [`SYNC_STAGES];
   int                    m_cnt;
   synth_pkg::env_state_t m_state;
   int                    m_level;
   logic [7:0]            m_phase;
   int                    pwm_count;
   int                    exp_duty;
   int                    frames_used;

   synth_top dut_i (
      .clk      (clk),
      .rstn     (rstn),
      .sw       (sw),
      .note_enn (note_enn),
      .pwm_out  (pwm_out)
   );

   always #20 clk = ~clk;

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   function automatic synth_pkg::sample_t model_sample(input logic [7:0] ph,
                                                        input logic [1:0] ws);
      int v;
      case (ws)
         2'd0: v = int'(ph) - 128;
         2'd1: v = ph[7] ? -128 : 127;
         2'd2: v = (ph < 128) ? 2 * int'(ph) - 128 : 383 - 2 * int'(ph);
         default: v = 0;
      endcase
      return synth_pkg::sample_t'(v);
   endfunction

   task automatic check_duty(input synth_pkg::duty_t got, input synth_pkg::duty_t exp);
      if (got !== exp)
      begin
         $display("MISMATCH pwm duty: got %h expected %h", got, exp);
         $display("Checks failed");
         $fatal(1);
      end
   endtask

   task automatic check_level(input synth_pkg::env_level_t got,
                              input synth_pkg::env_level_t exp);
      if (got !== exp)
      begin
         $display("MISMATCH level: got %h expected %h", got, exp);
         $display("Checks failed");
         $fatal(1);
      end
   endtask

   task automatic check_sample(input synth_pkg::sample_t got, input synth_pkg::sample_t exp);
      if (got !== exp)
      begin
         $display("MISMATCH sample: got %h expected %h", got, exp);
         $display("Checks failed");
         $fatal(1);
      end
   endtask

   // reference model, runs on pre-edge values
   always @(posedge clk or negedge rstn)
   begin
      synth_pkg::switch_cfg_t cfg;
      logic [`NNOTES-1:0]     en;
      int                     key;
      int                     atk;
      int                     dec;
      int                     sus;
      int                     lv;
      int                     duty;
      logic [7:0]             step;
      if (!rstn)
      begin
         for (int i = 0; i < `SYNC_STAGES; i++)
         begin
            m_sw[i]  = '0;
            m_key[i] = '1;
         end
         m_cnt     = 0;
         m_state   = synth_pkg::env_idle;
         m_level   = 0;
         m_phase   = '0;
         pwm_count = 0;
         exp_duty  = 0;  // first frame stays low
      end
      else
      begin
         cfg = synth_pkg::switch_cfg_t'(m_sw[`SYNC_STAGES-1]);
         en  = ~m_key[`SYNC_STAGES-1];
         key = 0;
         for (int i = `NNOTES - 1; i >= 0; i--)
            if (en[i])
               key = i;
         pwm_count += int'(pwm_out);
         if (m_cnt == frame_len - 1)
         begin
            duty = (int'(model_sample(m_phase, cfg.wave_sel)) + m_level + `DUTY_OFFSET) % 256;
            if (duty < 0)
               duty += 256;
            check_duty(synth_pkg::duty_t'(pwm_count), synth_pkg::duty_t'(exp_duty));
            pwm_count = 0;
            exp_duty  = duty;
            step = 8'(int'(synth_pkg::scale_note(cfg.note_set, 3'(key))) - `NOTE_BASE);
            if (m_state != synth_pkg::env_idle)
               m_phase = m_phase + step;
            else
               m_phase = '0;
            atk = (cfg.adsr_sel[1]) ? `SLOW_STEP : `LEVEL_MAX;
            dec = (cfg.adsr_sel == 2'd3) ? `SLOW_STEP : `LEVEL_MAX;
            sus = (cfg.adsr_sel[0]) ? 0 : `LEVEL_MAX;
            if (en == '0)
            begin
               m_state = synth_pkg::env_idle;
               m_level = 0;
            end
            else if (m_state == synth_pkg::env_idle || m_state == synth_pkg::env_attack)
            begin
               lv = m_level + atk;
               m_level = (lv >= `LEVEL_MAX) ? `LEVEL_MAX : lv;
               m_state = (lv >= `LEVEL_MAX) ? synth_pkg::env_decay : synth_pkg::env_attack;
            end
            else if (m_state == synth_pkg::env_decay)
            begin
               lv = m_level - dec;
               m_level = (lv <= sus) ? sus : lv;
               if (lv <= sus)
                  m_state = synth_pkg::env_sustain;
            end
         end
         for (int i = `SYNC_STAGES - 1; i > 0; i--)
         begin
            m_sw[i]  = m_sw[i-1];
            m_key[i] = m_key[i-1];
         end
         m_sw[0]  = sw;
         m_key[0] = note_enn;
         m_cnt = (m_cnt + 1) % frame_len;
      end
   end

   // mid-cycle compare, everything settled
   always @(negedge clk)
   begin
      synth_pkg::switch_cfg_t cfg_now;
      cfg_now = synth_pkg::switch_cfg_t'(m_sw[`SYNC_STAGES-1]);
      if (rstn)
      begin
         check_level(dut_i.level, synth_pkg::env_level_t'(m_level));
         check_sample(dut_i.sample, model_sample(m_phase, cfg_now.wave_sel));
      end
   end

   task automatic hold_keys(input logic [7:0] sw_val, input logic [4:0] keys,
                            input int frames);
      @(posedge clk);
      sw       <= sw_val;
      note_enn <= keys;
      repeat (frames * frame_len - 1) @(posedge clk);
      frames_used += frames;
   endtask

   initial
   begin
      logic [31:0] r;
      clk         = 1'b0;
      rstn        = 1'b0;
      sw          = '0;
      note_enn    = '1;
      lfsr        = 32'he0c0;
      frames_used = 0;
      repeat (2) @(posedge clk);
      rstn <= 1'b1;
      hold_keys(8'h00, 5'b11111, 2);
      hold_keys({4'd3, 2'd3, 2'd0}, 5'b11110, 40);  // slow up, slow down
      hold_keys({4'd5, 2'd0, 2'd1}, 5'b11101, 5);
      hold_keys({4'd5, 2'd0, 2'd1}, 5'b11111, 2);   // release
      for (int w = 0; w < 4; w++)
         hold_keys({4'(w * 3), 2'd2, 2'(w)}, 5'b10111, 10);
      for (int c = 0; c < (run_frames - frames_used) * frame_len; c += 600)
      begin
         @(posedge clk);
         draw_bits(`NSWITCHES, r);
         sw <= r[`NSWITCHES-1:0];
         draw_bits(`NNOTES, r);
         note_enn <= r[`NNOTES-1:0];
         repeat (599) @(posedge clk);
      end
      $display("All checks passed");
      $finish;
   end

   initial
   begin
      #(limit_ns);
      $display("timeout, the run did not finish in time");
      $display("Checks failed");
      $fatal(1);
   end

endmodule

`default_nettype wire

// ==== synth_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "synth_macros.svh"

module synth_top (
   input  wire logic                    clk,
   input  wire logic                    rstn,
   input  wire logic [`NSWITCHES-1:0]   sw,
   input  wire logic [`NNOTES-1:0]      note_enn,
   output logic                         pwm_out
);

   synth_pkg::switch_cfg_t cfg;
   logic [`NNOTES-1:0]     note_en;
   synth_pkg::note_code_t  note;
   logic                   gate;
   synth_pkg::env_level_t  level;
   logic                   active;
   synth_pkg::sample_t     sample;
   logic                   frame_tick;

   input_sync sync_i (
      .clk      (clk),
      .rstn     (rstn),
      .sw       (sw),
      .note_enn (note_enn),
      .cfg      (cfg),
      .note_en  (note_en)
   );

   note_select sel_i (
      .cfg_note_set (cfg.note_set),
      .note_en      (note_en),
      .note         (note),
      .gate         (gate)
   );

   adsr_env env_i (
      .clk        (clk),
      .rstn       (rstn),
      .frame_tick (frame_tick),
      .gate       (gate),
      .adsr_sel   (cfg.adsr_sel),
      .level      (level),
      .active     (active)
   );

   wave_osc osc_i (
      .clk        (clk),
      .rstn       (rstn),
      .frame_tick (frame_tick),
      .active     (active),
      .note       (note),
      .wave_sel   (cfg.wave_sel),
      .sample     (sample)
   );

   pwm_dac dac_i (
      .clk        (clk),
      .rstn       (rstn),
      .sample     (sample),
      .level      (level),
      .frame_tick (frame_tick),
      .pwm_out    (pwm_out)
   );

endmodule

`default_nettype wire

// ==== wave_osc.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "synth_macros.svh"

module wave_osc (
   input  wire logic                   clk,
   input  wire logic                   rstn,
   input  wire logic                   frame_tick,
   input  wire logic                   active,
   input  wire synth_pkg::note_code_t  note,
   input  wire logic [1:0]             wave_sel,
   output synth_pkg::sample_t          sample
);

   logic [7:0] phase;
   logic [7:0] step;

   assign step = 8'(note) - 8'(`NOTE_BASE);

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
         phase <= '0;
      else if (frame_tick)
      begin
         if (active)
            phase <= phase + step;  // wraps mod 256
         else
            phase <= '0;
      end
   end

   always_comb
   begin
      case (wave_sel)
         2'd0: sample = synth_pkg::sample_t'(phase - 8'd128);  // saw
         2'd1: sample = phase[7] ? -8'sd128 : 8'sd127;
         2'd2:
         begin
            // triangle, rising half then falling half
            if (!phase[7])
               sample = synth_pkg::sample_t'({phase[6:0], 1'b0} - 8'd128);
            else
               sample = synth_pkg::sample_t'(8'd127 - {phase[6:0], 1'b0});
         end
         default: sample = '0;  // silent
      endcase
   end

endmodule

`default_nettype wire
